// File: rtl/noc_cfg_pkg.sv
package noc_cfg_pkg;

  // Router ports of the chain network
  localparam int NumPorts = 3;

  localparam int PortLocal = 0;
  localparam int PortEast  = 1;
  localparam int PortWest  = 2;

  // Virtual channels per link
  localparam int NumVc   = 2;
  localparam int VcWidth = (NumVc > 1) ? $clog2(NumVc) : 1;

  // Node ids along the chain
  localparam int IdWidth = 2;

  // One bit per output port, indexed by the port constants above
  typedef logic [NumPorts-1:0] port_sel_t;

  localparam port_sel_t SelLocal = port_sel_t'(1) << PortLocal;
  localparam port_sel_t SelEast  = port_sel_t'(1) << PortEast;
  localparam port_sel_t SelWest  = port_sel_t'(1) << PortWest;

endpackage

// File: rtl/noc_flit_pkg.sv
package noc_flit_pkg;

  localparam int FlitWidth = 32;

  // Bits left after last, vc and the two ids
  localparam int HdrPayloadWidth =
    FlitWidth - 1 - noc_cfg_pkg::VcWidth - 2 * noc_cfg_pkg::IdWidth;
  localparam int BodyDataWidth = FlitWidth - 1 - noc_cfg_pkg::VcWidth;

  // Head flit of a packet
  typedef struct packed {
    logic                               last;
    logic [noc_cfg_pkg::VcWidth-1:0]    vc;
    logic [noc_cfg_pkg::IdWidth-1:0]    dst_id;
    logic [noc_cfg_pkg::IdWidth-1:0]    src_id;
    logic [HdrPayloadWidth-1:0]         payload;
  } flit_hdr_t;

  // Any flit after the head
  typedef struct packed {
    logic                               last;
    logic [noc_cfg_pkg::VcWidth-1:0]    vc;
    logic [BodyDataWidth-1:0]           data;
  } flit_body_t;

  // last and vc sit at the same bits in both views
  typedef union packed {
    flit_hdr_t  hdr;
    flit_body_t body;
  } flit_u;

endpackage

// File: rtl/noc_xbar_if.sv
`timescale 1ns/1ps

interface noc_xbar_if;

  // One element per input port
  logic [noc_cfg_pkg::NumPorts-1:0]                               req_valid;
  noc_cfg_pkg::port_sel_t [noc_cfg_pkg::NumPorts-1:0]             req_port;
  logic [noc_cfg_pkg::NumPorts-1:0][noc_cfg_pkg::VcWidth-1:0]     req_vc;
  noc_flit_pkg::flit_u [noc_cfg_pkg::NumPorts-1:0]                req_flit;

  // gnt[k][j] is the grant of output j to input k
  noc_cfg_pkg::port_sel_t [noc_cfg_pkg::NumPorts-1:0]             gnt;

  modport requester (
    output req_valid, req_port, req_vc, req_flit,
    input  gnt
  );

  modport allocator (
    input  req_valid, req_port, req_vc, req_flit,
    output gnt
  );

endinterface

// File: rtl/noc_input_port.sv
`timescale 1ns/1ps

module noc_input_port #(
  parameter int PortIdx = 0,
  parameter int VcDepth = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [noc_cfg_pkg::IdWidth-1:0]    my_id_i,
  input  logic                               data_v_i,
  input  noc_flit_pkg::flit_u                data_i,
  output logic                               credit_v_o,
  output logic [noc_cfg_pkg::VcWidth-1:0]    credit_id_o,
  noc_xbar_if.requester                      xbar
);

  localparam int NumVc    = noc_cfg_pkg::NumVc;
  localparam int VcW      = noc_cfg_pkg::VcWidth;
  localparam int PtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntWidth = $clog2(VcDepth + 1);

  noc_flit_pkg::flit_u     mem [NumVc][VcDepth];
  logic [PtrWidth-1:0]     wr_ptr [NumVc];
  logic [PtrWidth-1:0]     rd_ptr [NumVc];
  logic [CntWidth-1:0]     count [NumVc];
  logic [NumVc-1:0]        route_lock;
  noc_cfg_pkg::port_sel_t  route_q [NumVc];

  logic [VcW-1:0]          prio_q;
  logic [VcW-1:0]          sel_vc;
  logic [VcW-1:0]          wr_vc;
  logic                    sel_valid;
  logic                    deq;
  noc_flit_pkg::flit_u     front;
  noc_cfg_pkg::port_sel_t  route;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(VcDepth - 1)) begin
      return '0;
    end
    return ptr + PtrWidth'(1);
  endfunction

  assign wr_vc = data_i.body.vc;

  // Rotating priority over the non-empty VCs
  always_comb begin
    sel_valid = 1'b0;
    sel_vc    = prio_q;
    for (int i = NumVc - 1; i >= 0; i--) begin
      if (count[(int'(prio_q) + i) % NumVc] != '0) begin
        sel_valid = 1'b1;
        sel_vc    = VcW'((int'(prio_q) + i) % NumVc);
      end
    end
  end

  assign front = mem[sel_vc][rd_ptr[sel_vc]];

  // Dimension-order decision on the head, held for the rest of the packet
  always_comb begin
    if (route_lock[sel_vc]) begin
      route = route_q[sel_vc];
    end else if (front.hdr.dst_id > my_id_i) begin
      route = noc_cfg_pkg::SelEast;
    end else if (front.hdr.dst_id < my_id_i) begin
      route = noc_cfg_pkg::SelWest;
    end else begin
      route = noc_cfg_pkg::SelLocal;
    end
  end

  assign xbar.req_valid[PortIdx] = sel_valid;
  assign xbar.req_port[PortIdx]  = route;
  assign xbar.req_vc[PortIdx]    = sel_vc;
  assign xbar.req_flit[PortIdx]  = front;

  assign deq = sel_valid && (xbar.gnt[PortIdx] != '0);

  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem[wr_vc][wr_ptr[wr_vc]] <= data_i;
    end
    if (deq && !front.body.last) begin
      route_q[sel_vc] <= route;
    end
    if (deq) begin
      credit_id_o <= sel_vc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVc; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        count[v]  <= '0;
      end
      route_lock <= '0;
      prio_q     <= '0;
      credit_v_o <= 1'b0;
    end else begin
      for (int v = 0; v < NumVc; v++) begin
        if (data_v_i && wr_vc == VcW'(v)) begin
          wr_ptr[v] <= next_ptr(wr_ptr[v]);
        end
        if (deq && sel_vc == VcW'(v)) begin
          rd_ptr[v] <= next_ptr(rd_ptr[v]);
        end
        count[v] <= count[v] + CntWidth'(data_v_i && wr_vc == VcW'(v))
                             - CntWidth'(deq && sel_vc == VcW'(v));
      end
      if (deq) begin
        route_lock[sel_vc] <= !front.body.last;
      end
      if (sel_valid) begin
        prio_q <= VcW'((int'(sel_vc) + 1) % NumVc);
      end
      // One credit per flit that left the buffer
      credit_v_o <= deq;
    end
  end

  // Upstream must hold a credit, so a full VC is never written
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_v_i |-> count[wr_vc] != CntWidth'(VcDepth));

endmodule

// File: rtl/noc_output_port.sv
`timescale 1ns/1ps

module noc_output_port #(
  parameter int PortIdx = 0,
  parameter int VcDepth = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  noc_xbar_if.allocator                      xbar,
  output logic                               data_v_o,
  output noc_flit_pkg::flit_u                data_o,
  input  logic                               credit_v_i,
  input  logic [noc_cfg_pkg::VcWidth-1:0]    credit_id_i
);

  localparam int NumPorts = noc_cfg_pkg::NumPorts;
  localparam int NumVc    = noc_cfg_pkg::NumVc;
  localparam int VcW      = noc_cfg_pkg::VcWidth;
  localparam int InW      = $clog2(NumPorts);
  localparam int CntWidth = $clog2(VcDepth + 1);

  logic [CntWidth-1:0]   credit_cnt [NumVc];
  logic [NumPorts-1:0]   req;
  logic [NumPorts-1:0]   gnt;
  logic [InW-1:0]        rr_ptr;
  logic [InW-1:0]        lock_in;
  logic [InW-1:0]        win;
  logic [VcW-1:0]        lock_vc;
  logic [VcW-1:0]        win_vc;
  logic                  locked;
  logic                  gnt_any;
  noc_flit_pkg::flit_u   win_flit;

  // Inputs heading here with a credit left on their VC
  always_comb begin
    for (int k = 0; k < NumPorts; k++) begin
      req[k] = xbar.req_valid[k] && xbar.req_port[k][PortIdx]
               && (credit_cnt[xbar.req_vc[k]] != '0);
    end
  end

  always_comb begin
    gnt = '0;
    win = rr_ptr;
    if (locked) begin
      // Only the rest of the current packet may pass
      win      = lock_in;
      gnt[win] = req[win] && (xbar.req_vc[win] == lock_vc);
    end else begin
      for (int i = NumPorts - 1; i >= 0; i--) begin
        if (req[(int'(rr_ptr) + i) % NumPorts]) begin
          win = InW'((int'(rr_ptr) + i) % NumPorts);
        end
      end
      gnt[win] = req[win];
    end
  end

  assign gnt_any  = |gnt;
  assign win_vc   = xbar.req_vc[win];
  assign win_flit = xbar.req_flit[win];

  for (genvar k = 0; k < NumPorts; k++) begin : gen_gnt
    assign xbar.gnt[k][PortIdx] = gnt[k];
  end

  always_ff @(posedge clk_i) begin
    if (gnt_any) begin
      data_o <= win_flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVc; v++) begin
        credit_cnt[v] <= CntWidth'(VcDepth);
      end
      data_v_o <= 1'b0;
      locked   <= 1'b0;
      lock_in  <= '0;
      lock_vc  <= '0;
      rr_ptr   <= '0;
    end else begin
      data_v_o <= gnt_any;
      for (int v = 0; v < NumVc; v++) begin
        credit_cnt[v] <= credit_cnt[v]
                         - CntWidth'(gnt_any && win_vc == VcW'(v))
                         + CntWidth'(credit_v_i && credit_id_i == VcW'(v));
      end
      if (gnt_any) begin
        locked  <= !win_flit.body.last;
        lock_in <= win;
        lock_vc <= win_vc;
        rr_ptr  <= InW'((int'(win) + 1) % NumPorts);
      end
    end
  end

  // Input PortIdx takes at most one grant across all outputs
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(xbar.gnt[PortIdx]));

  // The VC carried by the leaving flit must still hold a credit
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_any |-> credit_cnt[win_flit.body.vc] != '0);

  // Downstream never returns more credits than it has slots
  for (genvar v = 0; v < NumVc; v++) begin : gen_cnt_chk
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_cnt[v] <= CntWidth'(VcDepth));
  end

endmodule

// File: rtl/noc_router.sv
`timescale 1ns/1ps

module noc_router #(
  parameter int VcDepth = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [noc_cfg_pkg::IdWidth-1:0]        my_id_i,

  input  logic [noc_cfg_pkg::NumPorts-1:0]       data_v_i,
  input  noc_flit_pkg::flit_u [noc_cfg_pkg::NumPorts-1:0] data_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]       credit_v_o,
  output logic [noc_cfg_pkg::NumPorts-1:0][noc_cfg_pkg::VcWidth-1:0] credit_id_o,

  output logic [noc_cfg_pkg::NumPorts-1:0]       data_v_o,
  output noc_flit_pkg::flit_u [noc_cfg_pkg::NumPorts-1:0] data_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]       credit_v_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0][noc_cfg_pkg::VcWidth-1:0] credit_id_i
);

  // Input ports request outputs here, outputs answer with grants
  noc_xbar_if i_xbar ();

  for (genvar p = 0; p < noc_cfg_pkg::NumPorts; p++) begin : gen_ports

    noc_input_port #(
      .PortIdx (p),
      .VcDepth (VcDepth)
    ) i_input_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .my_id_i     (my_id_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .xbar        (i_xbar.requester)
    );

    noc_output_port #(
      .PortIdx (p),
      .VcDepth (VcDepth)
    ) i_output_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .xbar        (i_xbar.allocator),
      .data_v_o    (data_v_o[p]),
      .data_o      (data_o[p]),
      .credit_v_i  (credit_v_i[p]),
      .credit_id_i (credit_id_i[p])
    );

  end

endmodule

// File: testbench/tb_noc_router.sv
`timescale 1ns/1ps

module tb_noc_router;

  localparam int NumPorts = noc_cfg_pkg::NumPorts;
  localparam int NumVc    = noc_cfg_pkg::NumVc;
  localparam int VcW      = noc_cfg_pkg::VcWidth;
  localparam int NumIds   = 1 << noc_cfg_pkg::IdWidth;
  localparam int NumKeys  = NumPorts * NumIds * NumVc;
  localparam int VcDepth  = 2;

  logic                                  clk_i;
  logic                                  rst_n_i;
  logic [noc_cfg_pkg::IdWidth-1:0]       my_id_i;
  logic [NumPorts-1:0]                   data_v_i;
  noc_flit_pkg::flit_u [NumPorts-1:0]    data_i;
  logic [NumPorts-1:0]                   credit_v_o;
  logic [NumPorts-1:0][VcW-1:0]          credit_id_o;
  logic [NumPorts-1:0]                   data_v_o;
  noc_flit_pkg::flit_u [NumPorts-1:0]    data_o;
  logic [NumPorts-1:0]                   credit_v_i;
  logic [NumPorts-1:0][VcW-1:0]          credit_id_i;

  // Trace entries in file order, hold length kept in ent_in for H lines
  byte         ent_kind [$];
  int          ent_in [$];
  int          ent_vc [$];
  int          ent_key [$];
  logic [31:0] ent_word [$];

  // Scoreboard keyed by (output, src_id, vc)
  logic [31:0] send_word [NumPorts][$];
  int          send_vc [NumPorts][$];
  int          send_key [NumPorts][$];
  logic [31:0] exp_word [NumKeys][$];
  int          exp_cyc [NumKeys][$];
  int          key_in [NumKeys];
  int          due_cyc [NumPorts][$];
  int          due_vc [NumPorts][$];
  int          up_cred [NumPorts][NumVc];
  int          hold_cnt [NumPorts][NumVc];
  int          pending [NumPorts];
  bit          in_pkt [NumPorts];
  int          cur_key [NumPorts];
  int          last_key [NumPorts];
  int          cycle, limit, n_flits, hold_total, hold_left;
  int          n_sent, n_credits, err_value, err_other;
  bit          in_reset;

  noc_router #(
    .VcDepth (VcDepth)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .my_id_i     (my_id_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic int key_of(int o, int src, int v);
    return (o * NumIds + src) * NumVc + v;
  endfunction

  task automatic load_trace();
    int fd, in_p, vc, out_p, n;
    logic [31:0] word;
    string line;
    int pkt_src [NumPorts][NumVc];
    bit mid [NumPorts][NumVc];
    noc_flit_pkg::flit_u f;
    fd = $fopen("testbench/router_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/router_trace.txt");
      err_other++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.getc(0) == "F") begin
          void'($sscanf(line.substr(1, line.len() - 1), "%d %d %h %d", in_p, vc, word, out_p));
          f = word;
          if (!mid[in_p][vc]) begin
            pkt_src[in_p][vc] = f.hdr.src_id;
          end
          mid[in_p][vc] = !f.body.last;
          ent_kind.push_back("F");
          ent_in.push_back(in_p);
          ent_vc.push_back(vc);
          ent_word.push_back(word);
          ent_key.push_back(key_of(out_p, pkt_src[in_p][vc], vc));
          key_in[key_of(out_p, pkt_src[in_p][vc], vc)] = in_p;
          n_flits++;
        end else if (line.getc(0) == "H") begin
          void'($sscanf(line.substr(1, line.len() - 1), "%d", n));
          ent_kind.push_back("H");
          ent_in.push_back(n);
          ent_vc.push_back(0);
          ent_word.push_back('0);
          ent_key.push_back(0);
          hold_total += n;
        end
      end
      $fclose(fd);
    end
  endtask

  // A head may not follow the same input while another input waited with a ready head
  task automatic check_fair(int o, int key);
    bit starved;
    int other;
    starved = 1'b0;
    other   = 0;
    if (last_key[o] >= 0 && key_in[last_key[o]] == key_in[key]) begin
      for (int k = key % NumVc; k < NumKeys; k += NumVc) begin
        if (k / (NumIds * NumVc) == o && key_in[k] != key_in[key] && exp_cyc[k].size() > 0) begin
          if (exp_cyc[k][0] <= cycle - 2 && exp_word[k].size() == pending[key_in[k]]) begin
            starved = 1'b1;
            other   = key_in[k];
          end
        end
      end
    end
    assert (!starved) else begin
      $display("Output %0d gave input %0d a second packet while input %0d was waiting",
               o, key_in[key], other);
      err_other++;
    end
  endtask

  task automatic take_flit(int o);
    noc_flit_pkg::flit_u f;
    int key, v;
    f = data_o[o];
    v = f.body.vc;
    if (!in_pkt[o]) begin
      check_fair(o, key_of(o, f.hdr.src_id, v));
      cur_key[o] = key_of(o, f.hdr.src_id, v);
    end
    key = cur_key[o];
    assert (exp_word[key].size() > 0) else begin
      $display("Unexpected flit %h on output %0d", f, o);
      err_other++;
    end
    if (exp_word[key].size() > 0) begin
      assert (f == exp_word[key][0]) else begin
        $display("Error route_out%0d: expected %h, actual %h", o, exp_word[key][0], f);
        err_value++;
      end
      void'(exp_word[key].pop_front());
      void'(exp_cyc[key].pop_front());
      pending[key_in[key]]--;
    end
    in_pkt[o] = !f.body.last;
    if (!in_pkt[o]) begin
      last_key[o] = key;
    end
    if (hold_left > 0) begin
      hold_cnt[o][v]++;
      assert (hold_cnt[o][v] <= VcDepth) else begin
        $display("Error backpressure_out%0d_vc%0d: expected at most %0d, actual %0d",
                 o, v, VcDepth, hold_cnt[o][v]);
        err_value++;
      end
    end
    due_cyc[o].push_back(cycle + 1 + int'($urandom % 3));
    due_vc[o].push_back(v);
  endtask

  task automatic check_outputs();
    int v;
    for (int p = 0; p < NumPorts; p++) begin
      if (in_reset) begin
        assert (data_v_o[p] === 1'b0 && credit_v_o[p] === 1'b0) else begin
          $display("Port %0d shows a valid flit or credit during reset", p);
          err_other++;
        end
      end else begin
        if (credit_v_o[p]) begin
          v = credit_id_o[p];
          n_credits++;
          up_cred[p][v]++;
          assert (up_cred[p][v] <= VcDepth) else begin
            $display("Input %0d returned a credit on VC %0d with no flit to match", p, v);
            err_other++;
          end
        end
        if (data_v_o[p]) begin
          take_flit(p);
        end
      end
    end
  endtask

  task automatic drive_inputs();
    int v, key;
    for (int p = 0; p < NumPorts; p++) begin
      credit_v_i[p] = 1'b0;
      if (hold_left == 0 && due_cyc[p].size() > 0) begin
        if (due_cyc[p][0] <= cycle) begin
          credit_v_i[p]  = 1'b1;
          credit_id_i[p] = VcW'(due_vc[p].pop_front());
          void'(due_cyc[p].pop_front());
        end
      end
      data_v_i[p] = 1'b0;
      if (!in_reset && send_word[p].size() > 0) begin
        v = send_vc[p][0];
        if (up_cred[p][v] > 0) begin
          key = send_key[p].pop_front();
          void'(send_vc[p].pop_front());
          up_cred[p][v]--;
          data_v_i[p] = 1'b1;
          data_i[p]   = send_word[p][0];
          exp_word[key].push_back(send_word[p].pop_front());
          exp_cyc[key].push_back(cycle);
          pending[p]++;
          n_sent++;
        end
      end
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #0.5;
    cycle++;
    check_outputs();
    drive_inputs();
    if (hold_left > 0) begin
      hold_left--;
    end
  endtask

  // Ends a run that stalls past the cycle budget
  initial begin
    wait (limit > 0);
    while (cycle <= limit) begin
      @(posedge clk_i);
    end
    $display("Timeout after %0d cycles with traffic still outstanding", cycle);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic bit idle();
    if (hold_left != 0) begin
      return 1'b0;
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (send_word[p].size() != 0 || pending[p] != 0 || due_cyc[p].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_idle();
    while (!idle()) begin
      step();
    end
  endtask

  initial begin
    rst_n_i     = 1'b0;
    my_id_i     = 2'd1;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    void'($urandom(38));
    for (int p = 0; p < NumPorts; p++) begin
      last_key[p] = -1;
      for (int v = 0; v < NumVc; v++) begin
        up_cred[p][v] = VcDepth;
      end
    end
    load_trace();
    limit = 40 * n_flits + hold_total + 200;
    in_reset = 1'b1;
    repeat (16) step();
    rst_n_i  = 1'b1;
    in_reset = 1'b0;
    // Each H line closes a group, its hold covers the group that follows
    for (int i = 0; i < ent_kind.size(); i++) begin
      if (ent_kind[i] == "H") begin
        wait_idle();
        hold_left = ent_in[i];
        hold_cnt  = '{default: 0};
      end else begin
        send_word[ent_in[i]].push_back(ent_word[i]);
        send_vc[ent_in[i]].push_back(ent_vc[i]);
        send_key[ent_in[i]].push_back(ent_key[i]);
      end
    end
    wait_idle();
    assert (n_credits == n_sent) else begin
      $display("Error credit_total: expected %0d, actual %0d", n_sent, n_credits);
      err_value++;
    end
    $display("Errors: %0d value, %0d other", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/router_trace.txt
# F <input port> <vc> <flit hex> <expected output port>
# H <cycles> withholds downstream credits while the next group of flits runs
F 0 0 20000011 1
F 0 1 70000044 1
F 1 1 C4000022 2
F 2 0 18000033 0
F 0 0 80000A01 1
F 0 1 C0000C05 1
F 2 0 80000B03 0
H 12
F 0 0 20000101 1
F 2 1 68000201 1
F 0 0 00000102 1
F 2 1 C0000202 1
F 0 0 80000103 1
H 0
F 0 0 20000401 1
F 2 0 28000301 1
F 0 0 80000402 1
F 2 0 80000302 1
F 0 0 20000403 1
F 2 0 28000303 1
F 0 0 80000404 1
F 2 0 80000304 1

// File: sources.f
rtl/noc_cfg_pkg.sv
rtl/noc_flit_pkg.sv
rtl/noc_xbar_if.sv
rtl/noc_input_port.sv
rtl/noc_output_port.sv
rtl/noc_router.sv
testbench/tb_noc_router.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_router
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
TRACE   := testbench/router_trace.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(TRACE)
	./$(SIM) | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
